/* Makefile */
# Verilator simulation of the rv_fetch front end

VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= rv_fetch.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_fetch.sv */
`include "fetch_defs.svh"

module tb_fetch
	import fetch_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int accept_target   = 2000;
	localparam int clk_period      = 20;
	localparam int watchdog_cycles = accept_target * 10;
	// redirects only once the sequential start has been seen
	localparam int redirect_start  = 20;

	logic      clk;
	logic      arst_n;
	logic      redirect;
	addr_t     dnpc;
	logic      id_valid;
	logic      id_ready;
	addr_t     id_pc;
	inst_t     id_inst;
	logic      wb_cyc;
	logic      wb_stb;
	addr_t     wb_adr;
	bus_word_t wb_dat;
	logic      wb_ack;

	integer      seed;
	logic [31:0] r;
	logic [31:0] r_hi;
	logic [31:0] r_lo;
	int          stall_left;
	int          cycle_cnt;
	int          accept_cnt;
	logic        accept;
	// reference pc and last redirect target
	addr_t       exp_pc;
	addr_t       redir_pc;
	logic        redir_pending;
	// values from the previous edge, for the hold checks
	addr_t       held_pc;
	inst_t       held_inst;
	addr_t       held_adr;

	fetch_top i_dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.redirect (redirect),
		.dnpc     (dnpc),
		.id_valid (id_valid),
		.id_ready (id_ready),
		.id_pc    (id_pc),
		.id_inst  (id_inst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_adr   (wb_adr),
		.wb_dat   (wb_dat),
		.wb_ack   (wb_ack)
	);

	wb_mem_model i_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_adr (wb_adr),
		.wb_dat (wb_dat),
		.wb_ack (wb_ack)
	);

	// instruction the memory holds at a given pc
	function automatic inst_t expected_inst(input addr_t a);
		return a[31:0] ^ 32'h9E37_79B9;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		$display("Test FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	always #(clk_period / 2) clk = ~clk;

	assign accept = id_valid && id_ready;

	// ********************
	// reference model
	// ********************

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exp_pc        <= `FETCH_RESET_PC;
			redir_pc      <= '0;
			redir_pending <= 1'b0;
			accept_cnt    <= 0;
		end else begin
			if (accept) begin
				accept_cnt <= accept_cnt + 1;
			end
			// redirect replaces the sequence, an item taken at the same edge is older
			if (redirect) begin
				exp_pc        <= dnpc;
				redir_pc      <= dnpc;
				redir_pending <= 1'b1;
			end else if (accept) begin
				exp_pc        <= exp_pc + addr_t'(4);
				redir_pending <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		held_pc   <= id_pc;
		held_inst <= id_inst;
		held_adr  <= wb_adr;
	end

	// ********************
	// stimulus
	// ********************

	initial begin
		seed       = 92;
		clk        = 1'b0;
		arst_n     = 1'b0;
		redirect   = 1'b0;
		dnpc       = '0;
		id_ready   = 1'b0;
		stall_left = 0;
		cycle_cnt  = 0;
		repeat (16) @(posedge clk);
		#2 arst_n = 1'b1;
		forever begin
			@(posedge clk);
			#2;
			r = $random(seed);
			// decode back-pressure, single cycles and short bursts
			if (stall_left > 0) begin
				id_ready   = 1'b0;
				stall_left = stall_left - 1;
			end else if (r[3:0] == 4'd0) begin
				id_ready   = 1'b0;
				stall_left = int'(r[6:4]);
			end else begin
				id_ready = (r[9:8] != 2'd0);
			end
			// rare one cycle redirect pulse to an aligned target
			redirect = (accept_cnt >= redirect_start) && (r[15:11] == 5'd0);
			r_hi = $random(seed);
			r_lo = $random(seed);
			dnpc = {r_hi, r_lo[31:2], 2'b00};
		end
	end

	// ********************
	// checks
	// ********************

	a_reset_quiet: assert property (@(posedge clk)
		!arst_n && cycle_cnt > 0 |-> !wb_cyc && !wb_stb && !id_valid)
		else report_mismatch("wb_cyc,wb_stb,id_valid in reset", 64'd0,
			64'({$sampled(wb_cyc), $sampled(wb_stb), $sampled(id_valid)}));

	a_release_quiet: assert property (@(posedge clk)
		$rose(arst_n) |-> !wb_cyc && !wb_stb && !id_valid)
		else report_mismatch("wb_cyc,wb_stb,id_valid after reset", 64'd0,
			64'({$sampled(wb_cyc), $sampled(wb_stb), $sampled(id_valid)}));

	a_first_pc: assert property (@(posedge clk) disable iff (!arst_n)
		accept && accept_cnt == 0 |-> id_pc == `FETCH_RESET_PC)
		else report_mismatch("id_pc", `FETCH_RESET_PC, $sampled(id_pc));

	// sequential order, redirects included through exp_pc
	a_pc_order: assert property (@(posedge clk) disable iff (!arst_n)
		accept |-> id_pc == exp_pc)
		else report_mismatch("id_pc", $sampled(exp_pc), $sampled(id_pc));

	a_inst_rule: assert property (@(posedge clk) disable iff (!arst_n)
		accept |-> id_inst == expected_inst(id_pc))
		else report_mismatch("id_inst", {32'd0, expected_inst($sampled(id_pc))},
			{32'd0, $sampled(id_inst)});

	// first item after a redirect is the target, nothing stale
	a_redirect_target: assert property (@(posedge clk) disable iff (!arst_n)
		accept && redir_pending |-> id_pc == redir_pc)
		else report_mismatch("id_pc", $sampled(redir_pc), $sampled(id_pc));

	a_hold_pc: assert property (@(posedge clk) disable iff (!arst_n)
		id_valid && !id_ready && !redirect |=> id_valid && id_pc == held_pc)
		else report_mismatch("id_pc", $sampled(held_pc), $sampled(id_pc));

	a_hold_inst: assert property (@(posedge clk) disable iff (!arst_n)
		id_valid && !id_ready && !redirect |=> id_valid && id_inst == held_inst)
		else report_mismatch("id_inst", {32'd0, $sampled(held_inst)},
			{32'd0, $sampled(id_inst)});

	a_stb_cyc: assert property (@(posedge clk) disable iff (!arst_n)
		wb_stb |-> wb_cyc)
		else report_mismatch("wb_cyc", 64'd1, 64'($sampled(wb_cyc)));

	a_adr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		wb_stb |-> wb_adr[2:0] == 3'b000)
		else report_mismatch("wb_adr", {$sampled(wb_adr[63:3]), 3'b000},
			$sampled(wb_adr));

	a_adr_hold: assert property (@(posedge clk) disable iff (!arst_n)
		wb_stb && !wb_ack |=> wb_stb && wb_adr == held_adr)
		else report_mismatch("wb_adr", $sampled(held_adr), $sampled(wb_adr));

	// ********************
	// end of run
	// ********************

	initial begin
		wait (accept_cnt == accept_target);
		@(negedge clk);
		$display("Test OK");
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("run timed out after %0t with %0d of %0d instructions accepted",
			$time, accept_cnt, accept_target);
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* bench/wb_mem_model.sv */
`include "fetch_defs.svh"

module wb_mem_model
	import fetch_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	// wishbone classic slave, read only
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  addr_t     wb_adr,
	output bus_word_t wb_dat,
	output logic      wb_ack
);

	timeunit 1ns;
	timeprecision 100ps;

	integer     seed;
	logic [31:0] pick;
	// wait states still to go in the current bus cycle
	logic [1:0] wait_left;
	logic       busy;

	// word stored at a 4 byte address, scrambled low address bits
	function automatic inst_t word_at(input addr_t a);
		return a[31:0] ^ 32'h9E37_79B9;
	endfunction

	initial begin
		seed = 92;
	end

	// ********************
	// slave response
	// ********************

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack    <= 1'b0;
			wb_dat    <= '0;
			wait_left <= 2'd0;
			busy      <= 1'b0;
		end else if (wb_ack) begin
			// single ack per cycle, master drops stb next
			wb_ack <= 1'b0;
			busy   <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!busy) begin
				// new bus cycle, 0 to 3 wait states
				pick = $random(seed);
				if (pick[1:0] == 2'd0) begin
					wb_ack <= 1'b1;
					wb_dat <= {word_at(wb_adr + addr_t'(4)), word_at(wb_adr)};
				end else begin
					wait_left <= pick[1:0] - 2'd1;
					busy      <= 1'b1;
				end
			end else if (wait_left == 2'd0) begin
				wb_ack <= 1'b1;
				wb_dat <= {word_at(wb_adr + addr_t'(4)), word_at(wb_adr)};
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

endmodule

/* common/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ********************
// fetch front end widths
// ********************

// byte address width, full rv64 address space
`define FETCH_ADDR_W 64

// one uncompressed instruction
`define FETCH_INST_W 32

// wishbone data bus, one doubleword per beat
`define FETCH_BUS_W 64

// first pc after reset, start of dram
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

`endif

/* common/fetch_pkg.sv */
`include "fetch_defs.svh"

// ********************
// shared fetch types
// ********************

package fetch_pkg;

	// byte address, also used for the pc
	typedef logic [`FETCH_ADDR_W-1:0] addr_t;

	// one 32 bit instruction word
	typedef logic [`FETCH_INST_W-1:0] inst_t;

	// raw wishbone read data, two instructions side by side
	typedef logic [`FETCH_BUS_W-1:0] bus_word_t;

	// what the IF/ID register hands to decode
	// pc in the upper bits, instruction in the lower bits
	typedef struct packed {
		addr_t pc;
		inst_t inst;
	} fetch_pair_t;

endpackage

/* fetch/fetch_top.sv */
module fetch_top
	import fetch_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	// redirect from execute
	input  logic      redirect,
	input  addr_t     dnpc,
	// towards decode
	output logic      id_valid,
	input  logic      id_ready,
	output addr_t     id_pc,
	output inst_t     id_inst,
	// wishbone classic, read only
	output logic      wb_cyc,
	output logic      wb_stb,
	output addr_t     wb_adr,
	input  bus_word_t wb_dat,
	input  logic      wb_ack
);

	// pc_gen to PC register
	addr_t       pc;
	logic        pc_valid;
	logic        pc_ready;
	// PC register to fetch unit
	addr_t       req_pc;
	logic        req_valid;
	logic        req_ready;
	// fetch unit to IF/ID register
	logic        rsp_valid;
	logic        rsp_ready;
	addr_t       rsp_pc;
	inst_t       rsp_inst;
	fetch_pair_t rsp_pair;
	fetch_pair_t id_pair;

	// ********************
	// pc stage
	// ********************

	pc_gen i_pc_gen (
		.clk      (clk),
		.arst_n   (arst_n),
		.redirect (redirect),
		.dnpc     (dnpc),
		.pc       (pc),
		.pc_valid (pc_valid),
		.pc_ready (pc_ready)
	);

	pipe_reg #(.payload_t(addr_t)) i_pc_reg (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (redirect),
		.in_valid  (pc_valid),
		.in_ready  (pc_ready),
		.in_data   (pc),
		.out_valid (req_valid),
		.out_ready (req_ready),
		.out_data  (req_pc)
	);

	// ********************
	// bus fetch and IF/ID
	// ********************

	wb_fetch i_wb_fetch (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (redirect),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_pc    (req_pc),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_adr    (wb_adr),
		.wb_dat    (wb_dat),
		.wb_ack    (wb_ack),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_pc    (rsp_pc),
		.rsp_inst  (rsp_inst)
	);

	// pack pc and instruction for the IF/ID register
	assign rsp_pair = '{pc: rsp_pc, inst: rsp_inst};

	pipe_reg #(.payload_t(fetch_pair_t)) i_ifid_reg (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (redirect),
		.in_valid  (rsp_valid),
		.in_ready  (rsp_ready),
		.in_data   (rsp_pair),
		.out_valid (id_valid),
		.out_ready (id_ready),
		.out_data  (id_pair)
	);

	assign id_pc   = id_pair.pc;
	assign id_inst = id_pair.inst;

endmodule

/* fetch/wb_fetch.sv */
`include "fetch_defs.svh"

module wb_fetch
	import fetch_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	// redirect drops the current fetch
	input  logic      flush,
	// request side with the pc from the PC register
	input  logic      req_valid,
	output logic      req_ready,
	input  addr_t     req_pc,
	// wishbone classic read master
	output logic      wb_cyc,
	output logic      wb_stb,
	output addr_t     wb_adr,
	input  bus_word_t wb_dat,
	input  logic      wb_ack,
	// response side towards the IF/ID register
	output logic      rsp_valid,
	input  logic      rsp_ready,
	output addr_t     rsp_pc,
	output inst_t     rsp_inst
);

	typedef enum logic [1:0] {
		s_idle,
		s_bus,
		s_hold
	} state_t;

	state_t state;
	// bus cycle still running but its data is stale
	logic   discard;
	logic   req_fire;
	// pc of the fetch in progress and its instruction
	addr_t  pc_q;
	inst_t  inst_q;

	// new request when idle or when the held response leaves now
	// nothing is taken while a flush is on since that request is stale too
	assign req_ready = !flush && ((state == s_idle) || (state == s_hold && rsp_ready));
	assign req_fire  = req_valid && req_ready;

	// ********************
	// state machine
	// ********************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= s_idle;
			discard <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					if (req_fire) begin
						state <= s_bus;
					end
				end
				s_bus: begin
					if (wb_ack) begin
						// bus cycle is over so keep the data only if nobody redirected
						state   <= (discard || flush) ? s_idle : s_hold;
						discard <= 1'b0;
					end else if (flush) begin
						// classic cycle cannot be abandoned so finish it and drop the data
						discard <= 1'b1;
					end
				end
				s_hold: begin
					if (flush || rsp_ready) begin
						state <= req_fire ? s_bus : s_idle;
					end
				end
				default: begin
					state <= s_idle;
				end
			endcase
		end
	end

	// ********************
	// payload
	// ********************

	always_ff @(posedge clk) begin
		if (req_fire) begin
			pc_q <= req_pc;
		end
		// pc bit 2 picks the instruction within the doubleword
		if (state == s_bus && wb_ack) begin
			inst_q <= pc_q[2] ? wb_dat[`FETCH_BUS_W-1:`FETCH_INST_W]
			                  : wb_dat[`FETCH_INST_W-1:0];
		end
	end

	// cyc and stb rise together and drop in the cycle after ack
	assign wb_cyc    = (state == s_bus);
	assign wb_stb    = (state == s_bus);
	assign wb_adr    = {pc_q[`FETCH_ADDR_W-1:3], 3'b000};

	assign rsp_valid = (state == s_hold);
	assign rsp_pc    = pc_q;
	assign rsp_inst  = inst_q;

	// ********************
	// bus checks
	// ********************

	// address held for the whole cycle until the slave acks
	a_adr_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr)
	);

endmodule

/* rtl/pc_gen.sv */
`include "fetch_defs.svh"

module pc_gen
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	// redirect from a later stage, dnpc is the new target
	input  logic  redirect,
	input  addr_t dnpc,
	// stage output towards the PC register
	output addr_t pc,
	output logic  pc_valid,
	input  logic  pc_ready
);

	// program counter and its valid flag
	addr_t pc_q;
	logic  pc_valid_q;

	// ********************
	// pc register
	// ********************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q       <= `FETCH_RESET_PC;
			pc_valid_q <= 1'b0;
		end else begin
			// always something to fetch once out of reset
			pc_valid_q <= 1'b1;
			if (redirect) begin
				// redirect wins over the sequential step
				pc_q <= dnpc;
			end else if (pc_valid_q && pc_ready) begin
				// accepted, step to the next instruction
				pc_q <= pc_q + addr_t'(4);
			end
		end
	end

	assign pc       = pc_q;
	assign pc_valid = pc_valid_q;

	// ********************
	// checks
	// ********************

	// misaligned pc can only come from a bad redirect target
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!arst_n)
		pc_valid |-> (pc[1:0] == 2'b00)
	);

endmodule

/* rtl/pipe_reg.sv */
module pipe_reg
	import fetch_pkg::*;
#(
	// payload carried through the slice
	parameter type payload_t = addr_t
) (
	input  logic     clk,
	input  logic     arst_n,
	// drop whatever is held, takes effect on the next edge
	input  logic     flush,
	// upstream side
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	// downstream side
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     valid_q;
	payload_t data_q;

	// take a new item when empty or when the current one leaves this cycle
	assign in_ready = !valid_q || out_ready;

	// ********************
	// control
	// ********************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	// payload, loaded on the input handshake only
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;

	// stalled output keeps its data until taken or flushed
	a_hold_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready && !flush |=> out_valid && $stable(out_data)
	);

endmodule

/* rv_fetch.f */
+incdir+common
common/fetch_pkg.sv
rtl/pc_gen.sv
rtl/pipe_reg.sv
fetch/wb_fetch.sv
fetch/fetch_top.sv
bench/wb_mem_model.sv
bench/tb_fetch.sv
